/* include/axi_directives.svh */
`ifndef AXI_DIRECTIVES_SVH
`define AXI_DIRECTIVES_SVH

// Catch undeclared nets in every RTL file
`default_nettype none

`endif

/* rtl/axi_lite_pkg.sv */
package axi_lite_pkg;

  // Bus widths
  localparam int axi_addr_width = 20;
  localparam int axi_data_width = 16;
  localparam int axi_strb_width = (axi_data_width + 7) / 8;

  // Response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Manager to subordinate
  typedef struct packed {
    logic [axi_addr_width-1:0] awaddr;
    logic                      awvalid;
    logic [axi_data_width-1:0] wdata;
    logic [axi_strb_width-1:0] wstrb;
    logic                      wvalid;
    logic                      bready;
    logic [axi_addr_width-1:0] araddr;
    logic                      arvalid;
    logic                      rready;
  } axi_lite_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      arready;
    logic [axi_data_width-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
  } axi_lite_rsp_t;

endpackage

/* rtl/axi_2x2.sv */
`include "axi_directives.svh"

module axi_2x2 (
  input  logic                        axi_clk,
  input  logic                        axi_resetn,

  input  logic                        switch_sel,
  output logic                        sel,

  input  axi_lite_pkg::axi_lite_req_t in0_req,
  output axi_lite_pkg::axi_lite_rsp_t in0_rsp,
  input  axi_lite_pkg::axi_lite_req_t in1_req,
  output axi_lite_pkg::axi_lite_rsp_t in1_rsp,

  output axi_lite_pkg::axi_lite_req_t out0_req,
  input  axi_lite_pkg::axi_lite_rsp_t out0_rsp,
  output axi_lite_pkg::axi_lite_req_t out1_req,
  input  axi_lite_pkg::axi_lite_rsp_t out1_rsp
);

  // One write and one read can be owed per bank
  localparam int cnt_width = 2;

  logic                 swap_pending;
  logic [cnt_width-1:0] out0_cnt;
  logic [cnt_width-1:0] out1_cnt;
  logic                 out0_addr_xfer;
  logic                 out1_addr_xfer;
  logic                 bus_idle;

  // Address handshake seen on an output this cycle
  function automatic logic addr_xfer(input axi_lite_pkg::axi_lite_req_t req,
                                     input axi_lite_pkg::axi_lite_rsp_t rsp);
    addr_xfer = (req.awvalid && rsp.awready) || (req.arvalid && rsp.arready);
  endfunction

  // Count up on AW/AR transfers and down on B/R transfers
  function automatic logic [cnt_width-1:0] next_cnt(input logic [cnt_width-1:0] cnt,
                                                    input axi_lite_pkg::axi_lite_req_t req,
                                                    input axi_lite_pkg::axi_lite_rsp_t rsp);
    logic [cnt_width-1:0] n;
    n = cnt;
    if (req.awvalid && rsp.awready) begin
      n = n + 1'b1;
    end
    if (req.arvalid && rsp.arready) begin
      n = n + 1'b1;
    end
    if (rsp.bvalid && req.bready) begin
      n = n - 1'b1;
    end
    if (rsp.rvalid && req.rready) begin
      n = n - 1'b1;
    end
    next_cnt = n;
  endfunction

  // Purely combinational crossbar
  assign out0_req = !sel ? in0_req : in1_req;
  assign out1_req = sel ? in0_req : in1_req;
  assign in0_rsp  = !sel ? out0_rsp : out1_rsp;
  assign in1_rsp  = sel ? out0_rsp : out1_rsp;

  assign out0_addr_xfer = addr_xfer(out0_req, out0_rsp);
  assign out1_addr_xfer = addr_xfer(out1_req, out1_rsp);

  // A new address accepted this cycle also makes a response owed
  assign bus_idle = (out0_cnt == '0) && (out1_cnt == '0) &&
                    !out0_addr_xfer && !out1_addr_xfer;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      out0_cnt <= '0;
      out1_cnt <= '0;
    end else begin
      out0_cnt <= next_cnt(out0_cnt, out0_req, out0_rsp);
      out1_cnt <= next_cnt(out1_cnt, out1_req, out1_rsp);
    end
  end

  // Swap waits until no transaction is in flight
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      sel          <= 1'b0;
      swap_pending <= 1'b0;
    end else if (swap_pending) begin
      if (bus_idle) begin
        sel          <= ~sel;
        swap_pending <= 1'b0;
      end
    end else if (switch_sel) begin
      swap_pending <= 1'b1;
    end
  end

endmodule

/* rtl/axi_lite_regfile.sv */
`include "axi_directives.svh"

module axi_lite_regfile #(
  parameter int num_regs = 8
) (
  input  logic                        axi_clk,
  input  logic                        axi_resetn,

  input  axi_lite_pkg::axi_lite_req_t req,
  output axi_lite_pkg::axi_lite_rsp_t rsp
);

  localparam int byte_shift = $clog2(axi_lite_pkg::axi_strb_width);
  localparam int word_width = axi_lite_pkg::axi_addr_width - byte_shift;
  localparam int idx_width  = (num_regs > 1) ? $clog2(num_regs) : 1;

  logic [axi_lite_pkg::axi_data_width-1:0] regs [num_regs];

  logic [word_width-1:0]                   wr_word;
  logic [word_width-1:0]                   rd_word;
  logic                                    wr_in_range;
  logic                                    rd_in_range;
  logic [idx_width-1:0]                    wr_idx;
  logic [idx_width-1:0]                    rd_idx;
  logic                                    wr_ready;
  logic                                    wr_fire;
  logic                                    rd_fire;

  logic                                    bvalid_q;
  logic [1:0]                              bresp_q;
  logic                                    rvalid_q;
  logic [1:0]                              rresp_q;
  logic [axi_lite_pkg::axi_data_width-1:0] rdata_q;

  // Word index from byte address
  assign wr_word     = req.awaddr[axi_lite_pkg::axi_addr_width-1:byte_shift];
  assign rd_word     = req.araddr[axi_lite_pkg::axi_addr_width-1:byte_shift];
  assign wr_in_range = (wr_word < num_regs);
  assign rd_in_range = (rd_word < num_regs);
  assign wr_idx      = wr_word[idx_width-1:0];
  assign rd_idx      = rd_word[idx_width-1:0];

  // AW and W are taken together with one outstanding of each kind
  assign wr_ready = req.awvalid && req.wvalid && !bvalid_q;
  assign wr_fire  = wr_ready;
  assign rd_fire  = req.arvalid && !rvalid_q;

  always_comb begin
    rsp.awready = wr_ready;
    rsp.wready  = wr_ready;
    rsp.bresp   = bresp_q;
    rsp.bvalid  = bvalid_q;
    rsp.arready = !rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = rresp_q;
    rsp.rvalid  = rvalid_q;
  end

  // Register array with byte strobes
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_fire && wr_in_range) begin
      for (int b = 0; b < axi_lite_pkg::axi_strb_width; b++) begin
        if (req.wstrb[b]) begin
          regs[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  // Write response
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (req.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (wr_fire) begin
      bresp_q <= wr_in_range ? axi_lite_pkg::resp_okay : axi_lite_pkg::resp_slverr;
    end
  end

  // Read response
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (rd_fire) begin
      rdata_q <= rd_in_range ? regs[rd_idx] : '0;
      rresp_q <= rd_in_range ? axi_lite_pkg::resp_okay : axi_lite_pkg::resp_slverr;
    end
  end

endmodule

/* rtl/axi_switch_top.sv */
`include "axi_directives.svh"

module axi_switch_top #(
  parameter int bank0_regs = 8,
  parameter int bank1_regs = 16
) (
  input  logic                        axi_clk,
  input  logic                        axi_resetn,

  input  logic                        switch_sel,
  output logic                        sel,

  input  axi_lite_pkg::axi_lite_req_t in0_req,
  output axi_lite_pkg::axi_lite_rsp_t in0_rsp,
  input  axi_lite_pkg::axi_lite_req_t in1_req,
  output axi_lite_pkg::axi_lite_rsp_t in1_rsp
);

  axi_lite_pkg::axi_lite_req_t out0_req;
  axi_lite_pkg::axi_lite_rsp_t out0_rsp;
  axi_lite_pkg::axi_lite_req_t out1_req;
  axi_lite_pkg::axi_lite_rsp_t out1_rsp;

  axi_2x2 axi_2x2_i (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .switch_sel (switch_sel),
    .sel        (sel),
    .in0_req    (in0_req),
    .in0_rsp    (in0_rsp),
    .in1_req    (in1_req),
    .in1_rsp    (in1_rsp),
    .out0_req   (out0_req),
    .out0_rsp   (out0_rsp),
    .out1_req   (out1_req),
    .out1_rsp   (out1_rsp)
  );

  // Bank 0 sits on output 0
  axi_lite_regfile #(
    .num_regs (bank0_regs)
  ) bank0_i (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .req        (out0_req),
    .rsp        (out0_rsp)
  );

  // Bank 1 sits on output 1
  axi_lite_regfile #(
    .num_regs (bank1_regs)
  ) bank1_i (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .req        (out1_req),
    .rsp        (out1_rsp)
  );

endmodule

/* verif/axi_switch_tb.sv */
module axi_switch_tb;

  localparam int max_lines       = 32;
  localparam int num_fields      = 8;
  localparam int cycles_per_line = 64;

  logic                        axi_clk;
  logic                        axi_resetn;
  logic                        switch_sel;
  logic                        sel;
  axi_lite_pkg::axi_lite_req_t in0_req;
  axi_lite_pkg::axi_lite_req_t in1_req;
  axi_lite_pkg::axi_lite_rsp_t in0_rsp;
  axi_lite_pkg::axi_lite_rsp_t in1_rsp;

  // Eight fields per stimulus line
  logic [axi_lite_pkg::axi_addr_width-1:0] stim_mem [max_lines*num_fields];
  logic [31:0]                             lcg_state = 32'd28;
  int                                      cycle_count = 0;
  int                                      cycle_limit = 0;

  axi_switch_top #(
    .bank0_regs (8),
    .bank1_regs (16)
  ) axi_switch_top_i (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .switch_sel (switch_sel),
    .sel        (sel),
    .in0_req    (in0_req),
    .in0_rsp    (in0_rsp),
    .in1_req    (in1_req),
    .in1_rsp    (in1_rsp)
  );

  initial begin
    axi_clk = 1'b0;
    forever #50 axi_clk = ~axi_clk;
  end

  always @(posedge axi_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $fatal(1, "Simulation timed out");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      $display("** FAIL **");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Back-pressure length of 0 to 3 cycles
  function automatic int next_stall_cycles();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[25:24]);
  endfunction

  task automatic set_req(input int port, input axi_lite_pkg::axi_lite_req_t value);
    if (port == 0) begin
      in0_req <= value;
    end else begin
      in1_req <= value;
    end
  endtask

  function automatic axi_lite_pkg::axi_lite_rsp_t port_rsp(input int port);
    return (port == 0) ? in0_rsp : in1_rsp;
  endfunction

  // AW and W go together and bready stays low afterwards
  task automatic issue_write(input int port,
                             input logic [axi_lite_pkg::axi_addr_width-1:0] addr,
                             input logic [axi_lite_pkg::axi_data_width-1:0] data,
                             input logic [axi_lite_pkg::axi_strb_width-1:0] strb);
    axi_lite_pkg::axi_lite_req_t r;
    axi_lite_pkg::axi_lite_rsp_t rsp;
    r         = '0;
    r.awaddr  = addr;
    r.awvalid = 1'b1;
    r.wdata   = data;
    r.wstrb   = strb;
    r.wvalid  = 1'b1;
    @(posedge axi_clk);
    set_req(port, r);
    do begin
      @(negedge axi_clk);
      rsp = port_rsp(port);
    end while (!(rsp.awready && rsp.wready));
    @(posedge axi_clk);
    set_req(port, '0);
  endtask

  task automatic finish_write(input int port, output logic [1:0] bresp);
    axi_lite_pkg::axi_lite_req_t r;
    axi_lite_pkg::axi_lite_rsp_t rsp;
    r        = '0;
    r.bready = 1'b1;
    repeat (next_stall_cycles()) @(posedge axi_clk);
    @(posedge axi_clk);
    set_req(port, r);
    do begin
      @(negedge axi_clk);
      rsp = port_rsp(port);
    end while (!rsp.bvalid);
    bresp = rsp.bresp;
    @(posedge axi_clk);
    set_req(port, '0);
  endtask

  task automatic do_read(input int port, input logic [axi_lite_pkg::axi_addr_width-1:0] addr,
                         output logic [axi_lite_pkg::axi_data_width-1:0] rdata,
                         output logic [1:0] rresp);
    axi_lite_pkg::axi_lite_req_t r;
    axi_lite_pkg::axi_lite_rsp_t rsp;
    r         = '0;
    r.araddr  = addr;
    r.arvalid = 1'b1;
    @(posedge axi_clk);
    set_req(port, r);
    do begin
      @(negedge axi_clk);
      rsp = port_rsp(port);
    end while (!rsp.arready);
    r = '0;
    @(posedge axi_clk);
    set_req(port, r);
    repeat (next_stall_cycles()) @(posedge axi_clk);
    r.rready = 1'b1;
    @(posedge axi_clk);
    set_req(port, r);
    do begin
      @(negedge axi_clk);
      rsp = port_rsp(port);
    end while (!rsp.rvalid);
    rdata = rsp.rdata;
    rresp = rsp.rresp;
    @(posedge axi_clk);
    set_req(port, '0);
  endtask

  task automatic pulse_swap();
    @(posedge axi_clk);
    switch_sel <= 1'b1;
    @(posedge axi_clk);
    switch_sel <= 1'b0;
  endtask

  task automatic wait_for_sel(input logic value);
    while (sel !== value) begin
      @(negedge axi_clk);
    end
  endtask

  initial begin
    int                                      num_lines;
    int                                      base;
    int                                      port;
    logic [3:0]                              op;
    logic [axi_lite_pkg::axi_addr_width-1:0] addr;
    logic [axi_lite_pkg::axi_data_width-1:0] data;
    logic [axi_lite_pkg::axi_strb_width-1:0] strb;
    logic [axi_lite_pkg::axi_data_width-1:0] exp_rdata;
    logic [1:0]                              exp_resp;
    logic                                    exp_sel;
    logic [axi_lite_pkg::axi_data_width-1:0] rdata;
    logic [1:0]                              resp;
    axi_resetn = 1'b0;
    switch_sel = 1'b0;
    in0_req    = '0;
    in1_req    = '0;
    for (int i = 0; i < max_lines * num_fields; i++) begin
      stim_mem[i] = '1;
    end
    $readmemh("verif/axi_switch_stim.txt", stim_mem);
    // All-ones operation marks the end of the file
    num_lines = 0;
    while (num_lines < max_lines && stim_mem[num_lines*num_fields] != '1) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("No stimulus lines were read from verif/axi_switch_stim.txt");
      $display("** FAIL **");
      $fatal(1, "Missing stimulus");
    end
    cycle_limit = num_lines * cycles_per_line;
    repeat (3) @(posedge axi_clk);
    axi_resetn <= 1'b1;
    for (int n = 0; n < num_lines; n++) begin
      base      = n * num_fields;
      op        = stim_mem[base][3:0];
      port      = int'(stim_mem[base+1][0]);
      addr      = stim_mem[base+2];
      data      = stim_mem[base+3][axi_lite_pkg::axi_data_width-1:0];
      strb      = stim_mem[base+4][axi_lite_pkg::axi_strb_width-1:0];
      exp_rdata = stim_mem[base+5][axi_lite_pkg::axi_data_width-1:0];
      exp_resp  = stim_mem[base+6][1:0];
      exp_sel   = stim_mem[base+7][0];
      case (op)
        4'h0: begin
          issue_write(port, addr, data, strb);
          finish_write(port, resp);
          check_value("bresp", 32'(resp), 32'(exp_resp));
        end
        4'h1: begin
          do_read(port, addr, rdata, resp);
          check_value("rdata", 32'(rdata), 32'(exp_rdata));
          check_value("rresp", 32'(resp), 32'(exp_resp));
        end
        4'h2: begin
          pulse_swap();
          wait_for_sel(exp_sel);
        end
        4'h3: begin
          issue_write(port, addr, data, strb);
          pulse_swap();
          // Routing has to hold while B is still owed
          repeat (4) begin
            @(negedge axi_clk);
            check_value("sel", 32'(sel), 32'(!exp_sel));
          end
          finish_write(port, resp);
          check_value("bresp", 32'(resp), 32'(exp_resp));
          wait_for_sel(exp_sel);
        end
        default: begin
          $display("Stimulus line %0d has an unknown operation code %0h", n, op);
          $display("** FAIL **");
          $fatal(1, "Bad stimulus");
        end
      endcase
      check_value("sel", 32'(sel), 32'(exp_sel));
    end
    $display("** PASS **");
    $finish;
  end

endmodule

/* verif/axi_switch_stim.txt */
// op port addr data strb exp_rdata exp_resp exp_sel
// op 0 write, 1 read, 2 swap, 3 swap during a write; resp 0 OKAY, 2 SLVERR
0 0 00004 1234 3 0000 0 0
0 1 00004 abcd 3 0000 0 0
1 0 00004 0000 0 1234 0 0
1 1 00004 0000 0 abcd 0 0
0 1 00006 5a5a 3 0000 0 0
2 0 00000 0000 0 0000 0 1
1 0 00004 0000 0 abcd 0 1
1 0 00006 0000 0 5a5a 0 1
1 1 00004 0000 0 1234 0 1
0 1 00004 00ff 1 0000 0 1
1 1 00004 0000 0 12ff 0 1
0 0 00004 7700 2 0000 0 1
1 0 00004 0000 0 77cd 0 1
0 1 00014 beef 3 0000 2 1
1 1 00014 0000 0 0000 2 1
0 0 00014 beef 3 0000 0 1
1 0 00014 0000 0 beef 0 1
3 0 00016 4242 3 0000 0 0
1 1 00016 0000 0 4242 0 0
2 0 00000 0000 0 0000 0 1
1 0 00016 0000 0 4242 0 1
1 1 00004 0000 0 12ff 0 1

/* flist.f */
+incdir+include
rtl/axi_lite_pkg.sv
rtl/axi_2x2.sv
rtl/axi_lite_regfile.sv
rtl/axi_switch_top.sv
verif/axi_switch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the AXI-Lite switch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module axi_switch_tb -o axi_switch_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/axi_switch_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
